/* logic/rs_pkg.sv */
// Shared sizes, unit types, issue port map and the row format of the reservation station

package rs_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	// Physical register tag, 32 registers
	localparam int tag_w = 5;
	// Branch queue index, carried with every row
	localparam int br_idx_w = 3;
	// Dispatch and broadcast lanes
	localparam int lanes_default = 2;
	// Rows in the table
	localparam int rows_default = 8;
	// Unit ports on the issue side
	localparam int num_fu_total = 6;
	// Distinct unit types
	localparam int num_fu_types = 5;

	//////////////////////////////////////////////////////////////////////
	// Unit types and port map
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		fu_alu,
		fu_ld,
		fu_mult,
		fu_br,
		fu_st
	} fu_type_e;

	// First port of each type, in enum order
	localparam int fu_base [num_fu_types] = '{0, 2, 3, 4, 5};
	// Ports per type, two ALUs and one of the rest
	localparam int fu_count [num_fu_types] = '{2, 1, 1, 1, 1};

	//////////////////////////////////////////////////////////////////////
	// Row format
	//////////////////////////////////////////////////////////////////////

	// Source operand, tag plus ready flag
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic             ready;
	} src_t;

	typedef struct packed {
		logic                busy;
		fu_type_e            fu;
		logic [tag_w-1:0]    dest;
		src_t                src1;
		src_t                src2;
		logic [br_idx_w-1:0] br_idx;
		logic [7:0]          op;      // opaque opcode tag, never decoded here
	} rs_row_t;

	// Idle row for ports and cleared entries
	localparam rs_row_t empty_row = '0;

endpackage

/* logic/cam_if.sv */
// Wakeup match bus between the reservation station and the tag matcher

`timescale 1ns/10ps

interface cam_if #(
	parameter int rows = rs_pkg::rows_default,
	parameter int lanes = rs_pkg::lanes_default
);

	// Broadcast side, one entry per CDB lane
	logic [lanes-1:0]                    en;
	logic [lanes-1:0][rs_pkg::tag_w-1:0] tags;

	// Stored source tags, src1 at index 0 and src2 at index 1
	logic [rows-1:0][1:0][rs_pkg::tag_w-1:0] row_tags;

	// Match per row and source, already ORed over lanes
	logic [rows-1:0][1:0] hits;

	// Station side
	modport requester (
		output en, tags, row_tags,
		input  hits
	);

	// Matcher side, purely combinational
	modport matcher (
		input  en, tags, row_tags,
		output hits
	);

endinterface

/* logic/psel_multi.sv */
// Multi-grant priority selector returning row indexes, lowest request first

`timescale 1ns/10ps

module psel_multi #(
	parameter int width = 8,
	parameter int grants = 2
) (
	input  logic [width-1:0]                      req,
	input  logic                                  en,
	output logic [grants-1:0][$clog2(width)-1:0]  idx,
	output logic [grants-1:0]                     idx_valid
);

	localparam int idx_w = $clog2(width);

	//////////////////////////////////////////////////////////////////////
	// Selection
	//////////////////////////////////////////////////////////////////////

	// Requests not yet taken by an earlier grant
	logic [width-1:0] remaining;

	always_comb begin
		// Disabled selector sees no requests at all
		remaining = en ? req : '0;

		for (int k = 0; k < grants; k++) begin
			idx[k] = '0;
			idx_valid[k] = 1'b0;

			// Scan from the top so the lowest set bit wins
			for (int i = width - 1; i >= 0; i--) begin
				if (remaining[i]) begin
					idx[k] = idx_w'(i);
					idx_valid[k] = 1'b1;
				end
			end

			// Remove the pick, next grant takes the next lowest
			if (idx_valid[k]) begin
				remaining[idx[k]] = 1'b0;
			end
		end
	end

endmodule

/* logic/tag_cam.sv */
// Tag matcher comparing both source tags of every row against the CDB lanes

`timescale 1ns/10ps

module tag_cam #(
	parameter int rows = rs_pkg::rows_default,
	parameter int lanes = rs_pkg::lanes_default
) (
	cam_if.matcher lookup
);

	//////////////////////////////////////////////////////////////////////
	// Match array
	//////////////////////////////////////////////////////////////////////

	// rows x 2 x lanes comparators, folded to one hit per source
	always_comb begin
		for (int r = 0; r < rows; r++) begin
			for (int s = 0; s < 2; s++) begin
				lookup.hits[r][s] = 1'b0;

				// Disabled lanes never match
				for (int l = 0; l < lanes; l++) begin
					if (lookup.en[l] && (lookup.tags[l] == lookup.row_tags[r][s])) begin
						lookup.hits[r][s] = 1'b1;
					end
				end
			end
		end
	end

endmodule

/* logic/reservation_station.sv */
// Reservation station row table with dispatch, wakeup, issue, stall shifting, squash and counters

`timescale 1ns/10ps

module reservation_station #(
	parameter int rows = rs_pkg::rows_default,
	parameter int lanes = rs_pkg::lanes_default
) (
	input  logic                                       clock,
	input  logic                                       rst_n,
	input  logic                                       enable,
	input  logic [lanes-1:0]                           dispatch_valid,
	input  rs_pkg::rs_row_t [lanes-1:0]                inst_in,
	input  logic [rs_pkg::br_idx_w-1:0]                br_idx_in,
	input  logic [lanes-1:0]                           cdb_en,
	input  logic [lanes-1:0][rs_pkg::tag_w-1:0]        cdb_tag,
	input  logic                                       squash,
	input  logic [rs_pkg::num_fu_total-1:0]            issue_stall,
	cam_if.requester                                   cam,
	output rs_pkg::rs_row_t [rs_pkg::num_fu_total-1:0] issue_out,
	output logic [$clog2(rows):0]                      free_rows_next,
	output logic                                       rs_full
);

	localparam int row_w = $clog2(rows);
	localparam int cnt_w = $clog2(rows) + 1;

	//////////////////////////////////////////////////////////////////////
	// State and internal signals
	//////////////////////////////////////////////////////////////////////

	rs_pkg::rs_row_t [rows-1:0] rs_table;
	rs_pkg::rs_row_t [rows-1:0] rs_table_next;

	// Dispatch placement
	logic [rows-1:0]             disp_req;
	logic [lanes-1:0][row_w-1:0] disp_idx;
	logic [lanes-1:0]            disp_idx_valid;

	// Issue requests per type, grants laid out by port number
	logic [rs_pkg::num_fu_types-1:0][rows-1:0]       issue_req;
	logic [rs_pkg::num_fu_total-1:0][row_w-1:0]      grant_idx;
	logic [rs_pkg::num_fu_total-1:0]                 grant_valid;

	//////////////////////////////////////////////////////////////////////
	// Broadcast to the tag matcher
	//////////////////////////////////////////////////////////////////////

	assign cam.en = cdb_en;
	assign cam.tags = cdb_tag;

	always_comb begin
		for (int r = 0; r < rows; r++) begin
			cam.row_tags[r][0] = rs_table[r].src1.tag;
			cam.row_tags[r][1] = rs_table[r].src2.tag;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Dispatch selection
	//////////////////////////////////////////////////////////////////////

	// Free rows, lowest index first
	always_comb begin
		for (int r = 0; r < rows; r++) begin
			disp_req[r] = !rs_table[r].busy;
		end
	end

	psel_multi #(
		.width(rows),
		.grants(lanes)
	) u_disp_sel (
		.req(disp_req),
		.en(enable),
		.idx(disp_idx),
		.idx_valid(disp_idx_valid)
	);

	//////////////////////////////////////////////////////////////////////
	// Issue selection
	//////////////////////////////////////////////////////////////////////

	// Ready means already set or hit by this cycle's broadcast
	always_comb begin
		for (int t = 0; t < rs_pkg::num_fu_types; t++) begin
			for (int r = 0; r < rows; r++) begin
				issue_req[t][r] = rs_table[r].busy &&
					(rs_table[r].fu == rs_pkg::fu_type_e'(t)) &&
					(rs_table[r].src1.ready || cam.hits[r][0]) &&
					(rs_table[r].src2.ready || cam.hits[r][1]);
			end
		end
	end

	// One selector per type, as many grants as that type has ports
	for (genvar t = 0; t < rs_pkg::num_fu_types; t++) begin : g_issue_sel
		psel_multi #(
			.width(rows),
			.grants(rs_pkg::fu_count[t])
		) u_issue_sel (
			.req(issue_req[t]),
			.en(enable),
			.idx(grant_idx[rs_pkg::fu_base[t] +: rs_pkg::fu_count[t]]),
			.idx_valid(grant_valid[rs_pkg::fu_base[t] +: rs_pkg::fu_count[t]])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Next table and issue ports
	//////////////////////////////////////////////////////////////////////

	always_comb begin : next_state
		int slot;

		rs_table_next = rs_table;
		issue_out = {rs_pkg::num_fu_total{rs_pkg::empty_row}};
		slot = 0;

		// Wakeup from both lanes
		for (int r = 0; r < rows; r++) begin
			rs_table_next[r].src1.ready = rs_table[r].src1.ready | cam.hits[r][0];
			rs_table_next[r].src2.ready = rs_table[r].src2.ready | cam.hits[r][1];
		end

		// Grants of a type fill its non-stalled ports in order
		for (int p = 0; p < rs_pkg::num_fu_total; p++) begin
			// First port of a type restarts at that type's grant 0
			for (int t = 0; t < rs_pkg::num_fu_types; t++) begin
				if (p == rs_pkg::fu_base[t]) begin
					slot = p;
				end
			end
			// Stalled port keeps empty_row, candidate stays for later
			if (!issue_stall[p]) begin
				if (grant_valid[slot]) begin
					issue_out[p] = rs_table[grant_idx[slot]];
					issue_out[p].src1.ready = 1'b1;
					issue_out[p].src2.ready = 1'b1;
					rs_table_next[grant_idx[slot]] = rs_pkg::empty_row;
				end
				slot++;
			end
		end

		// Dispatch into rows free at the start of the cycle
		for (int l = 0; l < lanes; l++) begin
			// No free row means the lane is dropped
			if (dispatch_valid[l] && disp_idx_valid[l]) begin
				rs_table_next[disp_idx[l]] = inst_in[l];
				rs_table_next[disp_idx[l]].br_idx = br_idx_in;
				rs_table_next[disp_idx[l]].busy = 1'b1;
				// Same-lane broadcast catches a tag produced this cycle
				rs_table_next[disp_idx[l]].src1.ready = inst_in[l].src1.ready |
					(cdb_en[l] && (cdb_tag[l] == inst_in[l].src1.tag));
				rs_table_next[disp_idx[l]].src2.ready = inst_in[l].src2.ready |
					(cdb_en[l] && (cdb_tag[l] == inst_in[l].src2.tag));
			end
		end

		// Mispredicted branch empties everything
		if (squash) begin
			rs_table_next = {rows{rs_pkg::empty_row}};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Counters and flags
	//////////////////////////////////////////////////////////////////////

	// Free rows after the coming edge
	always_comb begin
		free_rows_next = '0;
		for (int r = 0; r < rows; r++) begin
			free_rows_next = free_rows_next + cnt_w'(!rs_table_next[r].busy);
		end
	end

	// Full only when every row is occupied now
	always_comb begin
		rs_full = 1'b1;
		for (int r = 0; r < rows; r++) begin
			rs_full = rs_full & rs_table[r].busy;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Table register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rs_table <= {rows{rs_pkg::empty_row}};
		end else begin
			rs_table <= rs_table_next;
		end
	end

endmodule

/* logic/rs_top.sv */
// Top level of the reservation station with plain ports, station plus tag matcher

`timescale 1ns/10ps

module rs_top #(
	parameter int rows = rs_pkg::rows_default,
	parameter int lanes = rs_pkg::lanes_default
) (
	input  logic                                       clock,
	input  logic                                       rst_n,
	// Gates dispatch and issue together
	input  logic                                       enable,
	input  logic [lanes-1:0]                           dispatch_valid,
	input  rs_pkg::rs_row_t [lanes-1:0]                inst_in,
	input  logic [rs_pkg::br_idx_w-1:0]                br_idx_in,
	// Common data bus lanes
	input  logic [lanes-1:0]                           cdb_en,
	input  logic [lanes-1:0][rs_pkg::tag_w-1:0]        cdb_tag,
	input  logic [rs_pkg::num_fu_total-1:0]            issue_stall,
	// Branch resolved wrongly
	input  logic                                       squash,
	// Busy bit of each port marks a valid issue
	output rs_pkg::rs_row_t [rs_pkg::num_fu_total-1:0] issue_out,
	output logic [$clog2(rows):0]                      free_rows_next,
	output logic                                       rs_full
);

	//////////////////////////////////////////////////////////////////////
	// Wakeup match bus
	//////////////////////////////////////////////////////////////////////

	cam_if #(
		.rows(rows),
		.lanes(lanes)
	) cam_bus ();

	//////////////////////////////////////////////////////////////////////
	// Row table and selection
	//////////////////////////////////////////////////////////////////////

	reservation_station #(
		.rows(rows),
		.lanes(lanes)
	) u_station (
		.clock(clock),
		.rst_n(rst_n),
		.enable(enable),
		.dispatch_valid(dispatch_valid),
		.inst_in(inst_in),
		.br_idx_in(br_idx_in),
		.cdb_en(cdb_en),
		.cdb_tag(cdb_tag),
		.squash(squash),
		.issue_stall(issue_stall),
		.cam(cam_bus.requester),
		.issue_out(issue_out),
		.free_rows_next(free_rows_next),
		.rs_full(rs_full)
	);

	//////////////////////////////////////////////////////////////////////
	// Tag comparators
	//////////////////////////////////////////////////////////////////////

	// Hits feed wakeup and issue readiness in the same cycle
	tag_cam #(
		.rows(rows),
		.lanes(lanes)
	) u_cam (
		.lookup(cam_bus.matcher)
	);

endmodule

/* bench/rs_tb.sv */
// Testbench for the reservation station top level with clock, reset, LCG stimulus and checks

`timescale 1ns/10ps

module rs_tb;

	//////////////////////////////////////////////////////////////////////
	// DUT signals and bookkeeping
	//////////////////////////////////////////////////////////////////////

	logic                                       clock;
	logic                                       rst_n;
	logic                                       enable;
	logic [1:0]                                 dispatch_valid;
	rs_pkg::rs_row_t [1:0]                      inst_in;
	logic [rs_pkg::br_idx_w-1:0]                br_idx_in;
	logic [1:0]                                 cdb_en;
	logic [1:0][rs_pkg::tag_w-1:0]              cdb_tag;
	logic [rs_pkg::num_fu_total-1:0]            issue_stall;
	logic                                       squash;
	rs_pkg::rs_row_t [rs_pkg::num_fu_total-1:0] issue_out;
	logic [3:0]                                 free_rows_next;
	logic                                       rs_full;

	int          errors;
	int          checks;
	int          test_errs;
	int          tests_run;
	logic [31:0] lcg_state;

	rs_top uut (.*);

	// 100 ns period
	always #50 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [rs_pkg::tag_w-1:0] random_tag();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[22:18];
	endfunction

	// Random dest, src2 tag and opcode tag with src2 ready
	function automatic rs_pkg::rs_row_t make_row(input rs_pkg::fu_type_e fu,
		input logic [rs_pkg::tag_w-1:0] tag1, input logic rdy1);
		rs_pkg::rs_row_t row;
		row = rs_pkg::empty_row;
		row.fu = fu;
		row.dest = random_tag();
		row.src1.tag = tag1;
		row.src1.ready = rdy1;
		row.src2.tag = random_tag();
		row.src2.ready = 1'b1;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		row.op = lcg_state[15:8];
		return row;
	endfunction

	// Row as a port shows it with busy, dispatch branch index and both sources ready
	function automatic rs_pkg::rs_row_t issued_row(input rs_pkg::rs_row_t inst,
		input logic [rs_pkg::br_idx_w-1:0] br);
		rs_pkg::rs_row_t row;
		row = inst;
		row.busy = 1'b1;
		row.br_idx = br;
		row.src1.ready = 1'b1;
		row.src2.ready = 1'b1;
		return row;
	endfunction

	// Quiet inputs with enable left high
	task automatic drive_idle();
		dispatch_valid <= '0;
		inst_in <= {2{rs_pkg::empty_row}};
		br_idx_in <= '0;
		cdb_en <= '0;
		cdb_tag <= '0;
		issue_stall <= '0;
		squash <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks and bounded waits
	//////////////////////////////////////////////////////////////////////

	task automatic check_num(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_row(input string name, input rs_pkg::rs_row_t expected,
		input rs_pkg::rs_row_t actual);
		checks++;
		assert (expected == actual) else begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_ports_idle(input string name);
		for (int p = 0; p < rs_pkg::num_fu_total; p++) begin
			check_num(name, 0, int'(issue_out[p].busy));
		end
	endtask

	// Counts mid-cycle samples until the port issues
	task automatic wait_port_busy(input int port, input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!issue_out[port].busy && cycles < limit);
		if (!issue_out[port].busy) begin
			$display("Timeout: port %0d issued nothing within %0d cycles", port, limit);
			errors++;
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d failures", tests_run, name, test_errs);
		end
		test_errs = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rs_pkg::rs_row_t row_a;
		rs_pkg::rs_row_t row_b;
		logic [rs_pkg::tag_w-1:0] tag_a;
		logic [rs_pkg::tag_w-1:0] held_tags [4];
		int cycles;

		errors = 0;
		checks = 0;
		test_errs = 0;
		tests_run = 0;
		lcg_state = 32'h23dc7c7f;
		clock = 1'b0;
		rst_n = 1'b0;
		enable = 1'b1;
		dispatch_valid = '0;
		inst_in = {2{rs_pkg::empty_row}};
		br_idx_in = '0;
		cdb_en = '0;
		cdb_tag = '0;
		issue_stall = '0;
		squash = 1'b0;

		// Reset held over two edges
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_num("reset free rows", 8, int'(free_rows_next));
		check_num("reset full flag", 0, int'(rs_full));
		check_ports_idle("reset port busy");
		finish_test("reset state");

		// Ready ALU row issuing the cycle after dispatch
		row_a = make_row(rs_pkg::fu_alu, random_tag(), 1'b1);
		@(posedge clock);
		drive_idle();
		dispatch_valid <= 2'b01;
		inst_in[0] <= row_a;
		br_idx_in <= 3'd5;
		@(negedge clock);
		check_num("alu not yet issued", 0, int'(issue_out[0].busy));
		check_num("alu free during dispatch", 7, int'(free_rows_next));
		@(posedge clock);
		drive_idle();
		wait_port_busy(0, 4, cycles);
		check_num("alu issue latency", 1, cycles);
		check_row("alu issued row", issued_row(row_a, 3'd5), issue_out[0]);
		check_num("alu free after issue", 8, int'(free_rows_next));
		@(negedge clock);
		check_num("alu port cleared", 0, int'(issue_out[0].busy));
		finish_test("ready alu issue");

		// Load waiting on src1 until lane 1 wakes it
		tag_a = random_tag();
		row_a = make_row(rs_pkg::fu_ld, tag_a, 1'b0);
		@(posedge clock);
		dispatch_valid <= 2'b01;
		inst_in[0] <= row_a;
		br_idx_in <= 3'd2;
		@(negedge clock);
		check_num("load held at dispatch", 0, int'(issue_out[2].busy));
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		check_num("load held waiting", 0, int'(issue_out[2].busy));
		@(posedge clock);
		cdb_en <= 2'b10;
		cdb_tag[1] <= tag_a;
		@(negedge clock);
		check_row("load woken same cycle", issued_row(row_a, 3'd2), issue_out[2]);
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		check_num("load port cleared", 0, int'(issue_out[2].busy));

		// Second load catches its tag on the dispatch lane
		tag_a = random_tag();
		row_b = make_row(rs_pkg::fu_ld, tag_a, 1'b0);
		@(posedge clock);
		dispatch_valid <= 2'b01;
		inst_in[0] <= row_b;
		br_idx_in <= 3'd6;
		cdb_en <= 2'b01;
		cdb_tag[0] <= tag_a;
		@(negedge clock);
		check_num("load2 held at dispatch", 0, int'(issue_out[2].busy));
		@(posedge clock);
		drive_idle();
		wait_port_busy(2, 4, cycles);
		check_num("load2 issue latency", 1, cycles);
		check_row("load2 issued row", issued_row(row_b, 3'd6), issue_out[2]);

		// Third load woken while port 2 stalls keeps its ready bit
		tag_a = random_tag();
		row_a = make_row(rs_pkg::fu_ld, tag_a, 1'b0);
		@(posedge clock);
		drive_idle();
		dispatch_valid <= 2'b01;
		inst_in[0] <= row_a;
		br_idx_in <= 3'd3;
		@(posedge clock);
		drive_idle();
		issue_stall <= 6'b000100;
		cdb_en <= 2'b01;
		cdb_tag[0] <= tag_a;
		@(negedge clock);
		check_row("load3 stalled at wakeup", rs_pkg::empty_row, issue_out[2]);
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		check_row("load3 issued after wakeup", issued_row(row_a, 3'd3), issue_out[2]);
		finish_test("load wakeup");

		// Five pairs of unready multiplies into eight rows
		for (int k = 0; k < 5; k++) begin
			row_a = make_row(rs_pkg::fu_mult, random_tag(), 1'b0);
			row_b = make_row(rs_pkg::fu_mult, random_tag(), 1'b0);
			@(posedge clock);
			drive_idle();
			dispatch_valid <= 2'b11;
			inst_in[0] <= row_a;
			inst_in[1] <= row_b;
			@(negedge clock);
			check_num("fill free rows", (k < 4) ? 6 - 2 * k : 0, int'(free_rows_next));
			check_num("fill full flag", (k == 4) ? 1 : 0, int'(rs_full));
			check_num("fill mult idle", 0, int'(issue_out[3].busy));
		end
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		check_num("full after drop", 1, int'(rs_full));
		check_num("free after drop", 0, int'(free_rows_next));
		// Empty the table for the next test
		@(posedge clock);
		squash <= 1'b1;
		@(negedge clock);
		check_num("fill squashed", 8, int'(free_rows_next));
		finish_test("table full");

		// Two ALUs with port 0 stalled for one cycle
		row_a = make_row(rs_pkg::fu_alu, random_tag(), 1'b1);
		row_b = make_row(rs_pkg::fu_alu, random_tag(), 1'b1);
		@(posedge clock);
		drive_idle();
		dispatch_valid <= 2'b11;
		inst_in[0] <= row_a;
		inst_in[1] <= row_b;
		br_idx_in <= 3'd1;
		@(negedge clock);
		check_ports_idle("stall nothing at dispatch");
		@(posedge clock);
		drive_idle();
		issue_stall <= 6'b000001;
		@(negedge clock);
		check_row("stalled port 0", rs_pkg::empty_row, issue_out[0]);
		check_row("lower row on port 1", issued_row(row_a, 3'd1), issue_out[1]);
		check_num("free with one left", 7, int'(free_rows_next));
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		check_row("second row on port 0", issued_row(row_b, 3'd1), issue_out[0]);
		check_num("port 1 idle", 0, int'(issue_out[1].busy));
		finish_test("stall shifting");

		// Squash over unready rows before their tags arrive
		for (int k = 0; k < 2; k++) begin
			held_tags[2 * k] = random_tag();
			held_tags[2 * k + 1] = random_tag();
			row_a = make_row((k == 0) ? rs_pkg::fu_br : rs_pkg::fu_st, held_tags[2 * k], 1'b0);
			row_b = make_row(rs_pkg::fu_alu, held_tags[2 * k + 1], 1'b0);
			@(posedge clock);
			drive_idle();
			dispatch_valid <= 2'b11;
			inst_in[0] <= row_a;
			inst_in[1] <= row_b;
		end
		@(posedge clock);
		drive_idle();
		squash <= 1'b1;
		@(negedge clock);
		check_num("squash free rows", 8, int'(free_rows_next));
		for (int k = 0; k < 2; k++) begin
			@(posedge clock);
			drive_idle();
			cdb_en <= 2'b11;
			cdb_tag[0] <= held_tags[2 * k];
			cdb_tag[1] <= held_tags[2 * k + 1];
			@(negedge clock);
			check_ports_idle("squashed rows issue");
			check_num("squash full flag", 0, int'(rs_full));
			check_num("squash free after", 8, int'(free_rows_next));
		end
		finish_test("squash");

		$display("tests %0d, checks %0d, failures %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
logic/rs_pkg.sv
logic/cam_if.sv
logic/psel_multi.sv
logic/tag_cam.sv
logic/reservation_station.sv
logic/rs_top.sv
bench/rs_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the reservation station testbench with Verilator, runs it and checks the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module rs_tb -o rs_sim

out="$(./obj_dir/rs_sim)"
echo "$out"

if grep -qx "Simulation PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi
